//--- hdl/ch2_pkg.sv
`default_nettype none

package ch2_pkg;

   // ------------------------------
   // vector types
   // ------------------------------
   typedef logic [15:0] ioreg_addr_t;    // cpu i/o register address
   typedef logic [7:0]  reg_byte_t;      // one sound register
   typedef logic [10:0] freq_t;          // {nr24[2:0], nr23}
   typedef logic [1:0]  duty_t;          // nr21[7:6]
   typedef logic [5:0]  length_t;        // nr21[5:0]
   typedef logic [3:0]  volume_t;        // envelope volume and sample
   typedef logic [2:0]  env_period_t;    // nr22[2:0]

   // ------------------------------
   // decoded channel settings
   // ------------------------------
   typedef struct packed {
      duty_t       duty;
      length_t     length;
      volume_t     env_init;     // nr22[7:4]
      logic        env_up;       // nr22[3]
      env_period_t env_period;
      freq_t       freq;
      logic        stop_en;      // nr24[6]
   } ch2_ctrl_t;

   // ------------------------------
   // register map
   // ------------------------------
   localparam ioreg_addr_t NR21_ADDR = 16'hFF16;   // duty, length
   localparam ioreg_addr_t NR22_ADDR = 16'hFF17;   // envelope
   localparam ioreg_addr_t NR23_ADDR = 16'hFF18;   // freq low, write only
   localparam ioreg_addr_t NR24_ADDR = 16'hFF19;   // restart, stop, freq high

   // envelope sequencing
   typedef enum logic [1:0] {
      ENV_IDLE,     // no restart seen yet
      ENV_RUN,      // stepping the volume
      ENV_HOLD      // saturated or fixed volume
   } env_state_t;

endpackage

`default_nettype wire

//--- hdl/ch2_regs.sv
`timescale 1ns/1ns
`default_nettype none

module ch2_regs (
   input  wire                 I_CLK_33MHZ,
   input  wire                 I_RESET,
   input  ch2_pkg::ioreg_addr_t ioreg_addr,
   input  ch2_pkg::reg_byte_t  ioreg_wdata,
   input  wire                 ioreg_we,
   input  wire                 ioreg_re,
   output ch2_pkg::reg_byte_t  ioreg_rdata,
   output ch2_pkg::ch2_ctrl_t  ctrl,
   output logic                restart
);

   ch2_pkg::reg_byte_t nr21;
   ch2_pkg::reg_byte_t nr22;
   ch2_pkg::reg_byte_t nr23;
   ch2_pkg::reg_byte_t nr24;
   ch2_pkg::reg_byte_t rd_val;

   // ------------------------------
   // register writes
   // ------------------------------
   always_ff @(posedge I_CLK_33MHZ) begin
      if (I_RESET) begin
         nr21 <= '0;
         nr22 <= '0;
         nr23 <= '0;
         nr24 <= '0;
      end else if (ioreg_we) begin
         case (ioreg_addr)
            ch2_pkg::NR21_ADDR: nr21 <= ioreg_wdata;
            ch2_pkg::NR22_ADDR: nr22 <= ioreg_wdata;
            ch2_pkg::NR23_ADDR: nr23 <= ioreg_wdata;
            ch2_pkg::NR24_ADDR: nr24 <= {1'b0, ioreg_wdata[6:0]};  // trigger bit not kept
            default: ;
         endcase
      end
   end

   // one cycle after the nr24 write edge
   always_ff @(posedge I_CLK_33MHZ) begin
      if (I_RESET) begin
         restart <= 1'b0;
      end else begin
         restart <= ioreg_we && (ioreg_addr == ch2_pkg::NR24_ADDR) && ioreg_wdata[7];
      end
   end

   // ------------------------------
   // readback
   // ------------------------------
   always_comb begin
      case (ioreg_addr)
         ch2_pkg::NR21_ADDR: rd_val = {nr21[7:6], 6'h3F};        // duty only
         ch2_pkg::NR22_ADDR: rd_val = nr22;
         ch2_pkg::NR23_ADDR: rd_val = 8'hFF;                     // write only
         ch2_pkg::NR24_ADDR: rd_val = {1'b1, nr24[6], 6'h3F};    // stop bit only
         default:            rd_val = 8'hFF;
      endcase
   end

   always_ff @(posedge I_CLK_33MHZ) begin
      if (I_RESET) begin
         ioreg_rdata <= 8'hFF;
      end else if (ioreg_re) begin
         ioreg_rdata <= rd_val;   // held until the next read
      end
   end

   assign ctrl.duty       = nr21[7:6];
   assign ctrl.length     = nr21[5:0];
   assign ctrl.env_init   = nr22[7:4];
   assign ctrl.env_up     = nr22[3];
   assign ctrl.env_period = nr22[2:0];
   assign ctrl.freq       = {nr24[2:0], nr23};
   assign ctrl.stop_en    = nr24[6];

   // restart is a single-cycle event for every downstream block
   a_restart_pulse : assert property (@(posedge I_CLK_33MHZ) disable iff (I_RESET)
      restart |=> !restart);

   a_strobe_excl : assert property (@(posedge I_CLK_33MHZ) disable iff (I_RESET)
      !(ioreg_we && ioreg_re));

endmodule

`default_nettype wire

//--- hdl/square_wave_gen.sv
`timescale 1ns/1ns
`default_nettype none

module square_wave_gen #(
   parameter int unsigned FREQ_PRESCALE = 4
) (
   input  wire              I_CLK_33MHZ,
   input  wire              I_RESET,
   input  ch2_pkg::freq_t   freq,
   input  ch2_pkg::duty_t   duty,
   input  wire              restart,
   output logic             wave_bit
);

   localparam int PRE_W = (FREQ_PRESCALE > 1) ? $clog2(FREQ_PRESCALE) : 1;

   logic [PRE_W-1:0] pre_cnt;
   logic             tick;
   ch2_pkg::freq_t   timer;
   logic             expire;
   logic [2:0]       step;
   logic [7:0]       pattern;

   // ------------------------------
   // prescaler and reload timer
   // ------------------------------
   assign tick   = (pre_cnt == PRE_W'(FREQ_PRESCALE - 1));
   assign expire = tick && (timer == '1);

   always_ff @(posedge I_CLK_33MHZ) begin
      if (I_RESET) begin
         pre_cnt <= '0;
         timer   <= '0;
         step    <= '0;
      end else if (restart) begin
         pre_cnt <= '0;
         timer   <= freq;
         step    <= '0;
      end else begin
         if (tick) begin
            pre_cnt <= '0;
         end else begin
            pre_cnt <= pre_cnt + 1'b1;
         end
         if (expire) begin
            timer <= freq;             // 2048 - freq counts per step
            step  <= step + 3'd1;
         end else if (tick) begin
            timer <= timer + 1'b1;
         end
      end
   end

   // ------------------------------
   // duty patterns, bit n is step n
   // ------------------------------
   always_comb begin
      case (duty)
         2'd0:    pattern = 8'b0000_0001;   // 12.5 %
         2'd1:    pattern = 8'b1000_0001;   // 25 %
         2'd2:    pattern = 8'b1000_0111;   // 50 %
         default: pattern = 8'b0111_1110;   // 75 %
      endcase
   end

   assign wave_bit = pattern[step];

   a_step_on_expire : assert property (@(posedge I_CLK_33MHZ) disable iff (I_RESET)
      (!expire && !restart) |=> (step == $past(step)));

endmodule

`default_nettype wire

//--- hdl/length_timer.sv
`timescale 1ns/1ns
`default_nettype none

module length_timer #(
   parameter int unsigned TICKS_256HZ = 128906
) (
   input  wire               I_CLK_33MHZ,
   input  wire               I_RESET,
   input  ch2_pkg::length_t  length,
   input  wire               stop_en,
   input  wire               restart,
   output logic              active
);

   logic [31:0] remain;
   logic [31:0] load_val;

   // one less than the full count, active ends when remain hits zero
   assign load_val = (32'd64 - 32'(length)) * 32'(TICKS_256HZ) - 32'd1;

   always_ff @(posedge I_CLK_33MHZ) begin
      if (I_RESET) begin
         active <= 1'b0;
         remain <= '0;
      end else if (restart) begin
         active <= 1'b1;
         remain <= load_val;
      end else if (active) begin
         if (remain != '0) begin
            remain <= remain - 32'd1;
         end else if (stop_en) begin
            active <= 1'b0;   // length expired
         end
      end
   end

   // the channel only starts sounding through a register trigger
   a_rise_after_restart : assert property (@(posedge I_CLK_33MHZ) disable iff (I_RESET)
      $rose(active) |-> $past(restart));

endmodule

`default_nettype wire

//--- hdl/envelope_mixer.sv
`timescale 1ns/1ns
`default_nettype none

module envelope_mixer #(
   parameter int unsigned TICKS_256HZ = 128906
) (
   input  wire                   I_CLK_33MHZ,
   input  wire                   I_RESET,
   input  wire                   wave_bit,
   input  wire                   active,
   input  ch2_pkg::volume_t      env_init,
   input  wire                   env_up,
   input  ch2_pkg::env_period_t  env_period,
   input  wire                   restart,
   output ch2_pkg::volume_t      sample
);

   ch2_pkg::env_state_t state;
   ch2_pkg::volume_t    volume;
   logic [31:0]         step_timer;
   logic [31:0]         step_load;
   logic                at_limit;

   // 64 Hz envelope clock times the step period
   assign step_load = 32'(env_period) * 32'd4 * 32'(TICKS_256HZ) - 32'd1;
   assign at_limit  = env_up ? (volume == 4'hF) : (volume == 4'h0);

   // ------------------------------
   // envelope FSM
   // ------------------------------
   always_ff @(posedge I_CLK_33MHZ) begin
      if (I_RESET) begin
         state      <= ch2_pkg::ENV_IDLE;
         volume     <= '0;
         step_timer <= '0;
      end else if (restart) begin
         volume     <= env_init;
         step_timer <= step_load;
         if (env_period != '0) begin
            state <= ch2_pkg::ENV_RUN;
         end else begin
            state <= ch2_pkg::ENV_HOLD;   // fixed volume
         end
      end else begin
         case (state)
            ch2_pkg::ENV_RUN: begin
               if (env_period == '0) begin
                  state <= ch2_pkg::ENV_HOLD;
               end else if (step_timer != '0) begin
                  step_timer <= step_timer - 32'd1;
               end else if (at_limit) begin
                  state <= ch2_pkg::ENV_HOLD;   // saturated at 0 or 15
               end else begin
                  step_timer <= step_load;
                  volume     <= env_up ? volume + 4'd1 : volume - 4'd1;
               end
            end
            default: ;   // idle and hold wait for restart
         endcase
      end
   end

   // ------------------------------
   // gated output sample
   // ------------------------------
   always_ff @(posedge I_CLK_33MHZ) begin
      if (I_RESET) begin
         sample <= '0;
      end else begin
         sample <= (active && wave_bit) ? volume : '0;
      end
   end

   a_step_in_run : assert property (@(posedge I_CLK_33MHZ) disable iff (I_RESET)
      (!restart && (state != ch2_pkg::ENV_RUN)) |=> (volume == $past(volume)));

endmodule

`default_nettype wire

//--- hdl/sound_channel2.sv
`timescale 1ns/1ns
`default_nettype none

module sound_channel2 #(
   parameter int unsigned TICKS_256HZ   = 128906,
   parameter int unsigned FREQ_PRESCALE = 4
) (
   input  wire                  I_CLK_33MHZ,
   input  wire                  I_RESET,
   input  ch2_pkg::ioreg_addr_t ioreg_addr,
   input  ch2_pkg::reg_byte_t   ioreg_wdata,
   input  wire                  ioreg_we,
   input  wire                  ioreg_re,
   output ch2_pkg::reg_byte_t   ioreg_rdata,
   output ch2_pkg::volume_t     ch2_sample,
   output wire                  ch2_active
);

   ch2_pkg::ch2_ctrl_t ctrl;
   wire                restart;
   wire                wave_bit;

   ch2_regs u_regs (
      .I_CLK_33MHZ (I_CLK_33MHZ),
      .I_RESET     (I_RESET),
      .ioreg_addr  (ioreg_addr),
      .ioreg_wdata (ioreg_wdata),
      .ioreg_we    (ioreg_we),
      .ioreg_re    (ioreg_re),
      .ioreg_rdata (ioreg_rdata),
      .ctrl        (ctrl),
      .restart     (restart)
   );

   // ------------------------------
   // parallel channel blocks
   // ------------------------------
   square_wave_gen #(.FREQ_PRESCALE(FREQ_PRESCALE)) u_wave (
      .I_CLK_33MHZ (I_CLK_33MHZ),
      .I_RESET     (I_RESET),
      .freq        (ctrl.freq),
      .duty        (ctrl.duty),
      .restart     (restart),
      .wave_bit    (wave_bit)
   );

   length_timer #(.TICKS_256HZ(TICKS_256HZ)) u_length (
      .I_CLK_33MHZ (I_CLK_33MHZ),
      .I_RESET     (I_RESET),
      .length      (ctrl.length),
      .stop_en     (ctrl.stop_en),
      .restart     (restart),
      .active      (ch2_active)
   );

   envelope_mixer #(.TICKS_256HZ(TICKS_256HZ)) u_env (
      .I_CLK_33MHZ (I_CLK_33MHZ),
      .I_RESET     (I_RESET),
      .wave_bit    (wave_bit),
      .active      (ch2_active),
      .env_init    (ctrl.env_init),
      .env_up      (ctrl.env_up),
      .env_period  (ctrl.env_period),
      .restart     (restart),
      .sample      (ch2_sample)
   );

endmodule

`default_nettype wire

//--- bench/tb_sound_channel2.sv
`timescale 1ns/1ns
`default_nettype none

module tb_sound_channel2;

   localparam int CLK_HALF   = 20;
   localparam int PERIOD_CYC = 64;    // one wave period at freq 2040
   localparam int LEN_CAP    = 600;   // length reported when active never falls

   logic                 I_CLK_33MHZ;
   logic                 I_RESET;
   ch2_pkg::ioreg_addr_t ioreg_addr;
   ch2_pkg::reg_byte_t   ioreg_wdata;
   logic                 ioreg_we;
   logic                 ioreg_re;
   ch2_pkg::reg_byte_t   ioreg_rdata;
   ch2_pkg::volume_t     ch2_sample;
   wire                  ch2_active;

   int          cycle_cnt = 0;
   int          trig_cycle = 0;
   int          budget = 0;
   int          err_byte = 0;
   int          err_volume = 0;
   int          err_count = 0;
   int          err_other = 0;
   logic [31:0] rng_state;
   string       lines[$];

   sound_channel2 #(.TICKS_256HZ(8), .FREQ_PRESCALE(1)) u_dut (
      .I_CLK_33MHZ (I_CLK_33MHZ),
      .I_RESET     (I_RESET),
      .ioreg_addr  (ioreg_addr),
      .ioreg_wdata (ioreg_wdata),
      .ioreg_we    (ioreg_we),
      .ioreg_re    (ioreg_re),
      .ioreg_rdata (ioreg_rdata),
      .ch2_sample  (ch2_sample),
      .ch2_active  (ch2_active)
   );

   initial begin
      I_CLK_33MHZ = 1'b0;
      forever #CLK_HALF I_CLK_33MHZ = ~I_CLK_33MHZ;
   end

   always @(posedge I_CLK_33MHZ) cycle_cnt <= cycle_cnt + 1;

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s ^ (s << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // register map readback: nr21 duty only, nr24 stop bit only, nr23 write only
   function automatic ch2_pkg::reg_byte_t read_value(input ch2_pkg::ioreg_addr_t addr,
                                                     input ch2_pkg::reg_byte_t data);
      case (addr)
         ch2_pkg::NR21_ADDR: return data | 8'h3F;
         ch2_pkg::NR22_ADDR: return data;
         ch2_pkg::NR24_ADDR: return data | 8'hBF;
         default:            return 8'hFF;
      endcase
   endfunction

   // ------------------------------
   // compare tasks
   // ------------------------------
   task automatic check_byte(input string name, input ch2_pkg::reg_byte_t exp_val,
                             input ch2_pkg::reg_byte_t act);
      if (act !== exp_val) begin
         err_byte++;
         $display("** Error: %s expected 0x%h, got 0x%h at %0t", name, exp_val, act, $time);
      end
   endtask

   task automatic check_volume(input string name, input ch2_pkg::volume_t exp_val,
                               input ch2_pkg::volume_t act);
      if (act !== exp_val) begin
         err_volume++;
         $display("** Error: %s expected 0x%h, got 0x%h at %0t", name, exp_val, act, $time);
      end
   endtask

   task automatic check_count(input string name, input int exp_val, input int act);
      if (act != exp_val) begin
         err_count++;
         $display("** Error: %s expected 0x%h, got 0x%h at %0t", name, exp_val, act, $time);
      end
   endtask

   task automatic print_error_counts();
      $display("errors: byte %0d, volume %0d, count %0d, other %0d",
               err_byte, err_volume, err_count, err_other);
   endtask

   // ------------------------------
   // bus and measurement tasks
   // ------------------------------
   task automatic reg_write(input ch2_pkg::ioreg_addr_t addr, input ch2_pkg::reg_byte_t data);
      @(negedge I_CLK_33MHZ);
      ioreg_addr  = addr;
      ioreg_wdata = data;
      ioreg_we    = 1'b1;
      @(negedge I_CLK_33MHZ);
      ioreg_we = 1'b0;
      if (addr == ch2_pkg::NR24_ADDR && data[7]) begin
         trig_cycle = cycle_cnt;   // cycle of the write edge
      end
   endtask

   task automatic reg_read(input ch2_pkg::ioreg_addr_t addr, output ch2_pkg::reg_byte_t data);
      @(negedge I_CLK_33MHZ);
      ioreg_addr = addr;
      ioreg_re   = 1'b1;
      @(negedge I_CLK_33MHZ);
      ioreg_re = 1'b0;
      data     = ioreg_rdata;
   endtask

   task automatic random_readback(input ch2_pkg::ioreg_addr_t addr, input int count);
      ch2_pkg::reg_byte_t data;
      ch2_pkg::reg_byte_t rd;
      repeat (count) begin
         rng_state = xorshift32(rng_state);
         data      = rng_state[7:0];
         reg_write(addr, data);
         reg_read(addr, rd);
         check_byte("ioreg_rdata", read_value(addr, data), rd);
      end
   endtask

   // active rises two edges after the trigger write
   task automatic measure_length(input int exp_len);
      int len;
      while (cycle_cnt < trig_cycle + 1) begin
         @(negedge I_CLK_33MHZ);
      end
      len = cycle_cnt - trig_cycle - 1;
      while (ch2_active && len < LEN_CAP) begin
         @(negedge I_CLK_33MHZ);
         len = cycle_cnt - trig_cycle - 1;
      end
      check_count("ch2_active length", exp_len, len);
   endtask

   task automatic count_high(input int exp_high);
      int n;
      n = 0;
      repeat (2) @(negedge I_CLK_33MHZ);   // sample lags the duty write
      repeat (PERIOD_CYC) begin
         @(negedge I_CLK_33MHZ);
         if (ch2_sample != '0) n++;
      end
      check_count("nonzero ch2_sample", exp_high, n);
   endtask

   task automatic peak_check(input int wait_cyc, input ch2_pkg::volume_t exp_max);
      ch2_pkg::volume_t peak;
      peak = '0;
      repeat (wait_cyc) @(negedge I_CLK_33MHZ);
      repeat (PERIOD_CYC) begin
         @(negedge I_CLK_33MHZ);
         if (ch2_sample > peak) peak = ch2_sample;
      end
      check_volume("ch2_sample peak", exp_max, peak);
   endtask

   task automatic parse_line(input string line, output string cmd, output logic [31:0] a,
                             output logic [31:0] b, output int n);
      a = '0;
      b = '0;
      n = $sscanf(line, "%s", cmd);
      if (cmd == "W" || cmd == "R") n = $sscanf(line, "%s %h %h", cmd, a, b);
      else if (cmd == "X") n = $sscanf(line, "%s %h %d", cmd, a, b);
      else n = $sscanf(line, "%s %d %d", cmd, a, b);
   endtask

   task automatic run_command(input string line);
      string              cmd;
      logic [31:0]        a;
      logic [31:0]        b;
      int                 n;
      ch2_pkg::reg_byte_t rd;
      parse_line(line, cmd, a, b, n);
      case (cmd)
         "W": reg_write(a[15:0], b[7:0]);
         "R": begin
            reg_read(a[15:0], rd);
            check_byte("ioreg_rdata", b[7:0], rd);
         end
         "X": random_readback(a[15:0], int'(b));
         "L": measure_length(int'(a));
         "D": count_high(int'(a));
         "E": peak_check(int'(a), b[3:0]);
         default: begin
            err_other++;
            $display("unknown command in golden file: %s", line);
         end
      endcase
   endtask

   // ------------------------------
   // main sequence and watchdog
   // ------------------------------
   initial begin
      int          fd;
      int          n;
      int          sum;
      string       line;
      string       cmd;
      logic [31:0] a;
      logic [31:0] b;
      I_RESET     = 1'b1;
      ioreg_addr  = '0;
      ioreg_wdata = '0;
      ioreg_we    = 1'b0;
      ioreg_re    = 1'b0;
      rng_state   = 32'd57;
      sum         = 0;
      fd = $fopen("bench/ch2_golden.txt", "r");
      if (fd == 0) begin
         err_other++;
         $display("could not open bench/ch2_golden.txt");
      end else begin
         while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0 && $sscanf(line, "%s", cmd) == 1 && cmd.substr(0, 0) != "#") begin
               lines.push_back(line);
               parse_line(line, cmd, a, b, n);
               case (cmd)
                  "X":     sum += 4 * int'(b);
                  "L":     sum += LEN_CAP + 2;
                  "D":     sum += PERIOD_CYC + 2;
                  "E":     sum += int'(a) + PERIOD_CYC;
                  default: sum += 2;
               endcase
            end
         end
         $fclose(fd);
      end
      budget = 2 * sum + 10000;   // set once, the watchdog starts on it
      repeat (10) @(negedge I_CLK_33MHZ);
      I_RESET = 1'b0;
      foreach (lines[i]) run_command(lines[i]);
      repeat (4) @(negedge I_CLK_33MHZ);
      print_error_counts();
      if (err_byte + err_volume + err_count + err_other == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

   initial begin
      wait (budget > 0);
      repeat (budget) @(posedge I_CLK_33MHZ);
      $display("timeout: the test sequence did not finish within %0d cycles", budget);
      print_error_counts();
      $display("SIMULATION FAILED");
      $finish;
   end

endmodule

`default_nettype wire

//--- bench/ch2_golden.txt
# W addr data | R addr expect | X addr count   (addr, data, expect in hex, count decimal)
# L expect_cycles | D expect_high | E wait expect_max   (all decimal)
R FF16 3F
R FF19 BF
X FF16 16
X FF17 16
X FF18 8
X FF19 16
W FF17 F0
W FF18 F8
W FF16 BC
W FF19 C7
L 32
W FF16 A8
W FF19 C7
L 192
W FF19 C7
E 100 15
W FF19 C7
L 192
W FF19 87
L 600
W FF16 00
D 8
W FF16 40
D 16
W FF16 80
D 32
W FF16 C0
D 48
W FF17 31
W FF19 87
E 160 0
W FF19 87
E 0 3
W FF17 C9
W FF19 87
E 160 15

//--- src.f
hdl/ch2_pkg.sv
hdl/ch2_regs.sv
hdl/square_wave_gen.sv
hdl/length_timer.sv
hdl/envelope_mixer.sv
hdl/sound_channel2.sv
bench/tb_sound_channel2.sv

//--- run_sim.sh
#!/bin/sh
# build and run the channel 2 testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f src.f --top-module tb_sound_channel2 \
      -Mdir obj_dir -o sim_ch2; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/sim_ch2 > sim.log 2>&1
status=$?
cat sim.log
if [ "$status" -ne 0 ]; then
   echo "simulator exited with status $status"
   exit 1
fi

if grep -q "SIMULATION FAILED" sim.log; then
   exit 1
fi
exit 0
